// ==== verilog/sa_pkg.sv ====
// Systolic engine package with array constants, operand and result types and controller states
`default_nettype none

package sa_pkg;

    // ========================================
    // Array geometry and data widths
    // ========================================
    localparam int ARRAY_DIM   = 4;
    localparam int ACT_W       = 8;
    localparam int WGT_W       = 8;
    localparam int OFM_W       = 8;
    localparam int PSUM_W      = 32;
    localparam int ADDR_W      = 16;
    localparam int CHN_W       = 16;
    localparam int SHIFT_W     = 5;
    localparam int ROW_W       = $clog2(ARRAY_DIM);

    // ========================================
    // Flow control and drain
    // ========================================
    localparam int RD_CREDITS  = 4;
    localparam int WR_CREDITS  = 2;
    localparam int RD_CRED_W   = $clog2(RD_CREDITS + 1);
    localparam int WR_CRED_W   = $clog2(WR_CREDITS + 1);

    // Zero steps until the last wavefront reaches PE(N-1,N-1)
    localparam int DRAIN_STEPS = 2 * ARRAY_DIM - 1;
    localparam int DRAIN_W     = $clog2(DRAIN_STEPS);

    // Scalar types
    typedef logic signed [ACT_W-1:0]  act_t;
    typedef logic signed [WGT_W-1:0]  wgt_t;
    typedef logic        [OFM_W-1:0]  ofm_t;
    typedef logic signed [PSUM_W-1:0] psum_t;
    typedef logic        [ADDR_W-1:0] addr_t;
    typedef logic        [CHN_W-1:0]  chn_t;

    // One element per row or column
    typedef act_t  [ARRAY_DIM-1:0]                act_vec_t;
    typedef wgt_t  [ARRAY_DIM-1:0]                wgt_vec_t;
    typedef ofm_t  [ARRAY_DIM-1:0]                ofm_vec_t;
    typedef psum_t [ARRAY_DIM-1:0][ARRAY_DIM-1:0] psum_mat_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_FEED,
        CTRL_DRAIN,
        CTRL_WRITE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/sa_job_ctrl.sv ====
// Job controller with config capture, credited read requests, beat counting and array drain
`timescale 1ns/1ps
`default_nettype none

module sa_job_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_vld,
    output logic                       cfg_rdy,
    input  sa_pkg::addr_t              act_base,
    input  sa_pkg::addr_t              wgt_base,
    input  sa_pkg::addr_t              ofm_base,
    input  sa_pkg::chn_t               chn,
    input  logic [sa_pkg::SHIFT_W-1:0] shift,
    input  sa_pkg::act_t               zp,
    output logic                       rd_req,
    output sa_pkg::addr_t              rd_act_addr,
    output sa_pkg::addr_t              rd_wgt_addr,
    input  logic                       rd_data_vld,
    output logic                       array_clear,
    output logic                       array_step,
    output logic                       feed_zero,
    output logic                       psum_final,
    output logic [sa_pkg::SHIFT_W-1:0] job_shift,
    output sa_pkg::act_t               job_zp,
    output sa_pkg::addr_t              job_ofm_base,
    input  logic                       write_done
);

    import sa_pkg::*;

    ctrl_state_t          state;
    ctrl_state_t          state_nxt;
    addr_t                act_base_q;
    addr_t                wgt_base_q;
    chn_t                 chn_q;
    chn_t                 req_cnt;
    chn_t                 beat_cnt;
    logic [RD_CRED_W-1:0] rd_credits;
    logic [DRAIN_W-1:0]   drain_cnt;
    logic                 cfg_fire;
    logic                 last_beat;
    logic                 drain_last;

    assign cfg_rdy    = (state == CTRL_IDLE);
    assign cfg_fire   = cfg_vld && cfg_rdy;
    assign last_beat  = (beat_cnt == chn_q - chn_t'(1));
    assign drain_last = (drain_cnt == DRAIN_W'(DRAIN_STEPS - 1));

    // ========================================
    // Job parameters, held until next config
    // ========================================
    always_ff @(posedge clk) begin
        if (cfg_fire) begin
            act_base_q   <= act_base;
            wgt_base_q   <= wgt_base;
            chn_q        <= chn;
            job_shift    <= shift;
            job_zp       <= zp;
            job_ofm_base <= ofm_base;
        end
    end

    // ========================================
    // FSM
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            CTRL_IDLE:  if (cfg_fire) state_nxt = CTRL_FEED;
            CTRL_FEED:  if (rd_data_vld && last_beat) state_nxt = CTRL_DRAIN;
            CTRL_DRAIN: if (drain_last) state_nxt = CTRL_WRITE;
            CTRL_WRITE: if (write_done) state_nxt = CTRL_IDLE;
            default:    state_nxt = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= CTRL_IDLE;
            psum_final <= 1'b0;
            drain_cnt  <= '0;
        end else begin
            state      <= state_nxt;
            // Psums settle on the edge that ends the last drain step
            psum_final <= (state == CTRL_DRAIN) && drain_last;
            drain_cnt  <= (state == CTRL_DRAIN) ? drain_cnt + DRAIN_W'(1) : '0;
        end
    end

    // ========================================
    // Read requests under credits
    // ========================================
    assign rd_req      = (state == CTRL_FEED) && (req_cnt != chn_q) && (rd_credits != '0);
    assign rd_act_addr = act_base_q + addr_t'(req_cnt);
    assign rd_wgt_addr = wgt_base_q + addr_t'(req_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_cnt    <= '0;
            beat_cnt   <= '0;
            rd_credits <= RD_CRED_W'(RD_CREDITS);
        end else begin
            if (cfg_fire) begin
                req_cnt  <= '0;
                beat_cnt <= '0;
            end else begin
                req_cnt  <= req_cnt + chn_t'(rd_req);
                beat_cnt <= beat_cnt + chn_t'(rd_data_vld);
            end
            rd_credits <= rd_credits - RD_CRED_W'(rd_req) + RD_CRED_W'(rd_data_vld);
        end
    end

    // Array sequencing
    assign array_clear = cfg_fire;
    assign array_step  = ((state == CTRL_FEED) && rd_data_vld) || (state == CTRL_DRAIN);
    assign feed_zero   = (state == CTRL_DRAIN);

    // Memory must not return more beats than were requested
    a_rd_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        rd_credits <= RD_CRED_W'(RD_CREDITS))
        else $error("read credit count above RD_CREDITS");

    a_rd_no_orphan_beat: assert property (@(posedge clk) disable iff (!rst_n)
        rd_data_vld |-> (rd_credits != RD_CRED_W'(RD_CREDITS)))
        else $error("read beat returned with no request outstanding");

endmodule

`default_nettype wire

// ==== verilog/sa_operand_skew.sv ====
// Operand skew stage delaying row r and column c by r and c steps to form the wavefront
`timescale 1ns/1ps
`default_nettype none

module sa_operand_skew (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             step,
    input  logic             feed_zero,
    input  sa_pkg::act_vec_t in_act,
    input  sa_pkg::wgt_vec_t in_wgt,
    output sa_pkg::act_vec_t skew_act,
    output sa_pkg::wgt_vec_t skew_wgt
);

    import sa_pkg::*;

    // Lane i carries activation row i and weight column i together
    for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_lane
        logic [ACT_W+WGT_W-1:0] lane_in;

        // Zeros flush the wavefront during drain
        assign lane_in = feed_zero ? '0 : {in_act[i], in_wgt[i]};

        if (i == 0) begin : g_direct
            assign {skew_act[i], skew_wgt[i]} = lane_in;
        end else begin : g_delay
            logic [ACT_W+WGT_W-1:0] lane_q [i];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int k = 0; k < i; k++) begin
                        lane_q[k] <= '0;
                    end
                end else if (step) begin
                    lane_q[0] <= lane_in;
                    for (int k = 1; k < i; k++) begin
                        lane_q[k] <= lane_q[k-1];
                    end
                end
            end

            // Oldest stage feeds the array edge
            assign {skew_act[i], skew_wgt[i]} = lane_q[i-1];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sa_pe_array.sv ====
// Output-stationary grid of MAC cells passing activations east and weights south
`timescale 1ns/1ps
`default_nettype none

module sa_pe_array (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear,
    input  logic              step,
    input  sa_pkg::act_vec_t  west_act,
    input  sa_pkg::wgt_vec_t  north_wgt,
    output sa_pkg::psum_mat_t psums
);

    import sa_pkg::*;

    act_t act_east  [ARRAY_DIM][ARRAY_DIM];
    wgt_t wgt_south [ARRAY_DIM][ARRAY_DIM];

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
            act_t                          act_in;
            wgt_t                          wgt_in;
            act_t                          act_q;
            wgt_t                          wgt_q;
            psum_t                         acc_q;
            logic signed [ACT_W+WGT_W-1:0] prod;

            // Edge cells take the skewed operands, inner cells the neighbour
            if (c == 0) begin : g_west_edge
                assign act_in = west_act[r];
            end else begin : g_west_link
                assign act_in = act_east[r][c-1];
            end

            if (r == 0) begin : g_north_edge
                assign wgt_in = north_wgt[c];
            end else begin : g_north_link
                assign wgt_in = wgt_south[r-1][c];
            end

            assign prod = act_in * wgt_in;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    act_q <= '0;
                    wgt_q <= '0;
                    acc_q <= '0;
                end else if (clear) begin
                    act_q <= '0;
                    wgt_q <= '0;
                    acc_q <= '0;
                end else if (step) begin
                    act_q <= act_in;
                    wgt_q <= wgt_in;
                    acc_q <= acc_q + psum_t'(prod);
                end
            end

            assign act_east[r][c]  = act_q;
            assign wgt_south[r][c] = wgt_q;
            assign psums[r][c]     = acc_q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sa_ofm_writer.sv ====
// Output writer capturing final psums, requantizing each row and writing under credits
`timescale 1ns/1ps
`default_nettype none

module sa_ofm_writer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       psum_final,
    input  sa_pkg::psum_mat_t          psums,
    input  logic [sa_pkg::SHIFT_W-1:0] job_shift,
    input  sa_pkg::act_t               job_zp,
    input  sa_pkg::addr_t              job_ofm_base,
    output logic                       wr_vld,
    output sa_pkg::addr_t              wr_addr,
    output sa_pkg::ofm_vec_t           wr_data,
    input  logic                       wr_credit,
    output logic                       write_done
);

    import sa_pkg::*;

    psum_mat_t            psum_q;
    logic                 busy;
    logic [ROW_W-1:0]     row_idx;
    logic [WR_CRED_W-1:0] wr_credits;
    logic                 last_row;

    // ReLU, then shift and zero point, wrapping in 8 bits
    function automatic ofm_t requant(psum_t p, logic [SHIFT_W-1:0] sh, act_t zero_pt);
        psum_t shifted;
        shifted = p >>> sh;
        if (p < 0) begin
            return '0;
        end
        return shifted[OFM_W-1:0] + $unsigned(zero_pt);
    endfunction

    // ========================================
    // Psum capture
    // ========================================
    always_ff @(posedge clk) begin
        if (psum_final) begin
            psum_q <= psums;
        end
    end

    // ========================================
    // Row issue
    // ========================================
    assign last_row = (row_idx == ROW_W'(ARRAY_DIM - 1));
    assign wr_vld   = busy && (wr_credits != '0);
    assign wr_addr  = job_ofm_base + addr_t'(row_idx);

    always_comb begin
        for (int c = 0; c < ARRAY_DIM; c++) begin
            wr_data[c] = requant(psum_q[row_idx][c], job_shift, job_zp);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            row_idx    <= '0;
            write_done <= 1'b0;
        end else begin
            write_done <= wr_vld && last_row;
            if (psum_final) begin
                busy    <= 1'b1;
                row_idx <= '0;
            end else if (wr_vld) begin
                row_idx <= row_idx + ROW_W'(1);
                if (last_row) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Slots returned by the sink
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_credits <= WR_CRED_W'(WR_CREDITS);
        end else begin
            wr_credits <= wr_credits - WR_CRED_W'(wr_vld) + WR_CRED_W'(wr_credit);
        end
    end

    // A new matrix must not land while rows are still going out
    a_wr_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        psum_final |-> !busy)
        else $error("psum_final arrived while rows were still being written");

    // Sink may only return slots it was given
    a_wr_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        wr_credits <= WR_CRED_W'(WR_CREDITS))
        else $error("write credit count above WR_CREDITS");

endmodule

`default_nettype wire

// ==== verilog/sa_top.sv ====
// Systolic matrix engine top connecting controller, skew stage, PE array and output writer
`timescale 1ns/1ps
`default_nettype none

module sa_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_vld,
    output logic                       cfg_rdy,
    input  sa_pkg::addr_t              act_base,
    input  sa_pkg::addr_t              wgt_base,
    input  sa_pkg::addr_t              ofm_base,
    input  sa_pkg::chn_t               chn,
    input  logic [sa_pkg::SHIFT_W-1:0] shift,
    input  sa_pkg::act_t               zp,
    output logic                       rd_req,
    output sa_pkg::addr_t              rd_act_addr,
    output sa_pkg::addr_t              rd_wgt_addr,
    input  logic                       rd_data_vld,
    input  sa_pkg::act_vec_t           rd_act,
    input  sa_pkg::wgt_vec_t           rd_wgt,
    output logic                       wr_vld,
    output sa_pkg::addr_t              wr_addr,
    output sa_pkg::ofm_vec_t           wr_data,
    input  logic                       wr_credit
);

    import sa_pkg::*;

    logic                array_clear;
    logic                array_step;
    logic                feed_zero;
    logic                psum_final;
    logic                write_done;
    logic [SHIFT_W-1:0]  job_shift;
    act_t                job_zp;
    addr_t               job_ofm_base;
    act_vec_t            skew_act;
    wgt_vec_t            skew_wgt;
    psum_mat_t           psums;

    // ========================================
    // Pipeline stages
    // ========================================
    sa_job_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_vld      (cfg_vld),
        .cfg_rdy      (cfg_rdy),
        .act_base     (act_base),
        .wgt_base     (wgt_base),
        .ofm_base     (ofm_base),
        .chn          (chn),
        .shift        (shift),
        .zp           (zp),
        .rd_req       (rd_req),
        .rd_act_addr  (rd_act_addr),
        .rd_wgt_addr  (rd_wgt_addr),
        .rd_data_vld  (rd_data_vld),
        .array_clear  (array_clear),
        .array_step   (array_step),
        .feed_zero    (feed_zero),
        .psum_final   (psum_final),
        .job_shift    (job_shift),
        .job_zp       (job_zp),
        .job_ofm_base (job_ofm_base),
        .write_done   (write_done)
    );

    sa_operand_skew u_skew (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (array_step),
        .feed_zero (feed_zero),
        .in_act    (rd_act),
        .in_wgt    (rd_wgt),
        .skew_act  (skew_act),
        .skew_wgt  (skew_wgt)
    );

    sa_pe_array u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (array_clear),
        .step      (array_step),
        .west_act  (skew_act),
        .north_wgt (skew_wgt),
        .psums     (psums)
    );

    sa_ofm_writer u_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .psum_final   (psum_final),
        .psums        (psums),
        .job_shift    (job_shift),
        .job_zp       (job_zp),
        .job_ofm_base (job_ofm_base),
        .wr_vld       (wr_vld),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_credit    (wr_credit),
        .write_done   (write_done)
    );

endmodule

`default_nettype wire

// ==== tests/sa_tb_tasks.svh ====
// Testbench tasks for job runs, reference model, result compares and random numbers
`ifndef SA_TB_TASKS_SVH
`define SA_TB_TASKS_SVH

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Extra cycles of latency, 0 to span-1
    function automatic int next_delay(input int span);
        lat_rng = xorshift32(lat_rng);
        return int'(lat_rng % 32'(span));
    endfunction

    task automatic load_random(input addr_t ab, input addr_t wb, input int n);
        for (int k = 0; k < n; k++) begin
            data_rng = xorshift32(data_rng);
            act_mem[addr_t'(ab + k)] = data_rng;
            data_rng = xorshift32(data_rng);
            wgt_mem[addr_t'(wb + k)] = data_rng;
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    function automatic ofm_vec_t model_row(input addr_t ab, input addr_t wb, input int n,
                                           input int r, input int sh, input act_t z);
        ofm_vec_t row;
        act_t     a;
        wgt_t     w;
        int       p;
        for (int c = 0; c < ARRAY_DIM; c++) begin
            p = 0;
            for (int k = 0; k < n; k++) begin
                a = act_mem[addr_t'(ab + k)][r];
                w = wgt_mem[addr_t'(wb + k)][c];
                p += int'(a) * int'(w);
            end
            // Negative sums clamp, the rest wrap in one byte
            if (p < 0) begin
                row[c] = '0;
            end else begin
                row[c] = ofm_t'((p >>> sh) + int'(z));
            end
        end
        return row;
    endfunction

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_ofm(input string name, input ofm_vec_t got, input ofm_vec_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %-28s passed", name);
        end else begin
            $display("test %-28s failed, %0d mismatches", name, err_cnt - errs_before);
        end
    endtask

    // ========================================
    // Job sequencing
    // ========================================
    task automatic wait_cfg_rdy(input string what);
        int cycles;
        cycles = 0;
        while (cfg_rdy !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > JOB_TIMEOUT) begin
                timeout_abort(what);
            end
        end
    endtask

    task automatic run_job(input addr_t ab, input addr_t wb, input addr_t ob, input int n,
                           input int sh, input act_t z);
        wr_log.delete();
        wait_cfg_rdy("cfg_rdy before a new job");
        act_base   = ab;
        wgt_base   = wb;
        ofm_base   = ob;
        chn        = chn_t'(n);
        shift      = SHIFT_W'(sh);
        zp         = z;
        exp_rd_act = ab;
        exp_rd_wgt = wb;
        cfg_vld    = 1'b1;
        @(negedge clk);
        // Junk on the config bus once the job holds its own copy
        cfg_vld  = 1'b0;
        act_base = ~ab;
        wgt_base = ~wb;
        ofm_base = ~ob;
        chn      = ~chn_t'(n);
        shift    = ~SHIFT_W'(sh);
        zp       = ~z;
        wait_cfg_rdy("cfg_rdy at the end of a job");
    endtask

    task automatic check_job(input addr_t ab, input addr_t wb, input addr_t ob, input int n,
                             input int sh, input act_t z);
        addr_t a;
        if (wr_log.size() != ARRAY_DIM) begin
            err_cnt++;
            $display("Job with ofm base %h wrote %0d rows instead of %0d",
                ob, wr_log.size(), ARRAY_DIM);
        end
        for (int i = 0; i < wr_log.size(); i++) begin
            compare_addr($sformatf("wr_addr write %0d", i), wr_log[i], addr_t'(ob + i));
        end
        for (int r = 0; r < ARRAY_DIM; r++) begin
            a = addr_t'(ob + r);
            if (!ofm_mem.exists(a)) begin
                err_cnt++;
                $display("Row %0d of job with ofm base %h was never written", r, ob);
            end else begin
                compare_ofm($sformatf("wr_data at %h", a), ofm_mem[a],
                    model_row(ab, wb, n, r, sh, z));
            end
        end
    endtask

    task automatic job(input addr_t ab, input addr_t wb, input addr_t ob, input int n,
                       input int sh, input act_t z);
        run_job(ab, wb, ob, n, sh, z);
        check_job(ab, wb, ob, n, sh, z);
    endtask

`endif

// ==== tests/tb_sa_top.sv ====
// Testbench for the systolic matrix engine with memory models, write sink and directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_sa_top;

    import sa_pkg::*;

    localparam int          JOB_TIMEOUT = 5000;
    localparam logic [31:0] SEED        = 32'hf98245ee;

    logic               clk;
    logic               rst_n;
    logic               cfg_vld;
    logic               cfg_rdy;
    addr_t              act_base;
    addr_t              wgt_base;
    addr_t              ofm_base;
    chn_t               chn;
    logic [SHIFT_W-1:0] shift;
    act_t               zp;
    logic               rd_req;
    addr_t              rd_act_addr;
    addr_t              rd_wgt_addr;
    logic               rd_data_vld;
    act_vec_t           rd_act;
    wgt_vec_t           rd_wgt;
    logic               wr_vld;
    addr_t              wr_addr;
    ofm_vec_t           wr_data;
    logic               wr_credit;

    // Memory models and write sink state
    act_vec_t    act_mem [addr_t];
    wgt_vec_t    wgt_mem [addr_t];
    ofm_vec_t    ofm_mem [addr_t];
    addr_t       wr_log [$];
    addr_t       rd_act_q [$];
    addr_t       rd_wgt_q [$];
    int          rd_due_q [$];
    int          cred_due_q [$];
    addr_t       exp_rd_act;
    addr_t       exp_rd_wgt;
    int          cyc;
    int          rd_lat_span;
    int          wr_lat_span;
    logic [31:0] data_rng;
    logic [31:0] lat_rng;
    int          err_cnt;
    int          check_cnt;
    int          test_cnt;

    sa_top uut (.*);

    task automatic timeout_abort(input string what);
        $display("Timeout after %0d cycles waiting for %s", JOB_TIMEOUT, what);
        $display("ERRORS FOUND");
        $finish;
    endtask

    `include "sa_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ========================================
    // Read memory and write sink
    // ========================================
    always @(negedge clk) begin
        if (!rst_n) begin
            cyc         = 0;
            rd_data_vld = 1'b0;
            rd_act      = '0;
            rd_wgt      = '0;
            wr_credit   = 1'b0;
            rd_act_q.delete();
            rd_wgt_q.delete();
            rd_due_q.delete();
            cred_due_q.delete();
        end else begin
            cyc++;
            // Beats come back in request order
            rd_data_vld = 1'b0;
            if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin
                void'(rd_due_q.pop_front());
                rd_act      = act_mem[rd_act_q.pop_front()];
                rd_wgt      = wgt_mem[rd_wgt_q.pop_front()];
                rd_data_vld = 1'b1;
            end
            if (rd_req) begin
                // Requests walk both vectors one channel step at a time
                compare_addr("rd_act_addr", rd_act_addr, exp_rd_act);
                compare_addr("rd_wgt_addr", rd_wgt_addr, exp_rd_wgt);
                exp_rd_act++;
                exp_rd_wgt++;
                rd_act_q.push_back(rd_act_addr);
                rd_wgt_q.push_back(rd_wgt_addr);
                rd_due_q.push_back(cyc + 1 + next_delay(rd_lat_span));
            end
            // One freed slot per cycle at most
            wr_credit = 1'b0;
            if (cred_due_q.size() != 0 && cred_due_q[0] <= cyc) begin
                void'(cred_due_q.pop_front());
                wr_credit = 1'b1;
            end
            if (wr_vld) begin
                ofm_mem[wr_addr] = wr_data;
                wr_log.push_back(wr_addr);
                cred_due_q.push_back(cyc + 1 + next_delay(wr_lat_span));
            end
        end
    end

    // ========================================
    // Directed tests
    // ========================================
    task automatic test_reset_idle();
        int e0;
        e0 = err_cnt;
        compare_bit("cfg_rdy", cfg_rdy, 1'b1);
        repeat (12) begin
            @(negedge clk);
            compare_bit("rd_req", rd_req, 1'b0);
            compare_bit("wr_vld", wr_vld, 1'b0);
        end
        finish_test("reset idle", e0);
    endtask

    task automatic test_single_step();
        int e0;
        e0 = err_cnt;
        // Element 3 first in each concatenation
        act_mem[16'h0100] = {8'sd7, -8'sd3, 8'sd12, 8'sd1};
        wgt_mem[16'h0200] = {-8'sd5, 8'sd9, 8'sd2, 8'sd11};
        job(16'h0100, 16'h0200, 16'h0300, 1, 0, 8'sd0);
        finish_test("single step outer product", e0);
    endtask

    task automatic test_random_job();
        int e0;
        e0 = err_cnt;
        load_random(16'h1000, 16'h2000, 20);
        job(16'h1000, 16'h2000, 16'h3000, 20, 6, 8'sd37);
        finish_test("random chn 20", e0);
    endtask

    task automatic test_slow_credits();
        int       e0;
        ofm_vec_t prompt_rows [ARRAY_DIM];
        e0 = err_cnt;
        load_random(16'h4000, 16'h5000, 12);
        rd_lat_span = 1;
        wr_lat_span = 1;
        job(16'h4000, 16'h5000, 16'h6000, 12, 4, -8'sd9);
        for (int r = 0; r < ARRAY_DIM; r++) begin
            prompt_rows[r] = ofm_mem[addr_t'(16'h6000 + r)];
        end
        // Same job with long read latency and slow slot return
        rd_lat_span = 14;
        wr_lat_span = 11;
        job(16'h4000, 16'h5000, 16'h6100, 12, 4, -8'sd9);
        for (int r = 0; r < ARRAY_DIM; r++) begin
            compare_ofm($sformatf("wr_data slow row %0d", r), ofm_mem[addr_t'(16'h6100 + r)],
                prompt_rows[r]);
        end
        rd_lat_span = 3;
        wr_lat_span = 2;
        finish_test("slow memory and credits", e0);
    endtask

    task automatic test_back_to_back();
        int       e0;
        ofm_vec_t first_rows [ARRAY_DIM];
        e0 = err_cnt;
        load_random(16'h7000, 16'h7100, 9);
        load_random(16'h7400, 16'h7500, 5);
        job(16'h7000, 16'h7100, 16'h7200, 9, 2, -8'sd60);
        for (int r = 0; r < ARRAY_DIM; r++) begin
            first_rows[r] = ofm_mem[addr_t'(16'h7200 + r)];
        end
        job(16'h7400, 16'h7500, 16'h7600, 5, 1, 8'sd100);
        // First job's rows must be left alone
        for (int r = 0; r < ARRAY_DIM; r++) begin
            compare_ofm($sformatf("wr_data first job row %0d", r),
                ofm_mem[addr_t'(16'h7200 + r)], first_rows[r]);
        end
        finish_test("back to back jobs", e0);
    endtask

    initial begin
        err_cnt     = 0;
        check_cnt   = 0;
        test_cnt    = 0;
        data_rng    = SEED;
        lat_rng     = xorshift32(SEED);
        rd_lat_span = 3;
        wr_lat_span = 2;
        exp_rd_act  = '0;
        exp_rd_wgt  = '0;
        rst_n       = 1'b0;
        cfg_vld     = 1'b0;
        act_base    = '0;
        wgt_base    = '0;
        ofm_base    = '0;
        chn         = '0;
        shift       = '0;
        zp          = '0;
        rd_data_vld = 1'b0;
        rd_act      = '0;
        rd_wgt      = '0;
        wr_credit   = 1'b0;
        repeat (16) @(negedge clk);
        rst_n <= 1'b1;

        test_reset_idle();
        test_single_step();
        test_random_job();
        test_slow_credits();
        test_back_to_back();

        $display("Summary: %0d tests, %0d checks, %0d mismatches", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tests
verilog/sa_pkg.sv
verilog/sa_job_ctrl.sv
verilog/sa_operand_skew.sv
verilog/sa_pe_array.sv
verilog/sa_ofm_writer.sv
verilog/sa_top.sv
tests/tb_sa_top.sv

// ==== Bender.yml ====
package:
  name: sa_engine

sources:
  - files:
      - verilog/sa_pkg.sv
      - verilog/sa_job_ctrl.sv
      - verilog/sa_operand_skew.sv
      - verilog/sa_pe_array.sv
      - verilog/sa_ofm_writer.sv
      - verilog/sa_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_sa_top.sv
